//--- vlog.f
+incdir+test
src/FetchPkg.sv
src/FetchStageIF.sv
src/RecoveryIF.sv
src/NextPcStage.sv
src/BranchPredictor.sv
src/FetchStage.sv
src/FetchFrontEnd.sv
test/FetchFrontEndTb.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - src/FetchPkg.sv
      - src/FetchStageIF.sv
      - src/RecoveryIF.sv
      - src/NextPcStage.sv
      - src/BranchPredictor.sv
      - src/FetchStage.sv
      - src/FetchFrontEnd.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/FetchFrontEndTb.sv

//--- test/FetchTbTasks.svh
/*
 * Compare, wait and report tasks and the directed tests
 * of the fetch front-end testbench
 */

task automatic checkPc(input string name, input FetchPkg::PcPath expected,
                       input FetchPkg::PcPath actual);
    if (actual !== expected) begin
        errorCount++;
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic checkValid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        errorCount++;
        $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
endtask

// Consecutive slot PCs with the slots in the following cache line invalid
task automatic checkGroup(input string name, input FetchPkg::PcPath start);
    FetchPkg::PcPath slotPc;
    logic sameLine;
    for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
        slotPc = start + FetchPkg::PcPath'(i * FetchPkg::INSN_BYTES);
        sameLine = (slotPc / FetchPkg::LINE_BYTES) == (start / FetchPkg::LINE_BYTES);
        checkPc(name, slotPc, fetchPc[i]);
        checkValid(name, sameLine, fetchValid[i]);
    end
endtask

task automatic checkEmpty(input string name);
    for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
        checkValid(name, 1'b0, fetchValid[i]);
    end
endtask

// Expects a taken prediction on the given slot alone, or on none for a negative slot
task automatic checkTaken(input string name, input int slot);
    for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
        checkValid(name, i == slot, fetchPredTaken[i]);
    end
endtask

task automatic waitForGroup(input string name, input FetchPkg::PcPath pc, input int limit);
    logic found;
    found = 1'b0;
    for (int n = 0; n < limit && !found; n++) begin
        @(negedge clk);
        found = (fetchValid[0] === 1'b1) && (fetchPc[0] === pc);
    end
    if (!found) begin
        errorCount++;
        $display("Test %s: no fetch group at %h within %0d cycles", name, pc, limit);
    end
endtask

task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
        $display("Test %s done, no errors", name);
    end else begin
        failedTests++;
        $display("Test %s done, %0d errors", name, errorCount - errorsBefore);
    end
endtask

function automatic FetchPkg::PcPath groupAfter(input FetchPkg::PcPath pc);
    return pc + FetchPkg::PcPath'(FetchPkg::FETCH_WIDTH * FetchPkg::INSN_BYTES);
endfunction

// Line-aligned PC in a region of its own
function automatic FetchPkg::PcPath randomLinePc(input FetchPkg::PcPath region);
    return region | (FetchPkg::PcPath'($urandom) & 32'h0000_fff0);
endfunction

task automatic sequentialFetch();
    string name;
    int errorsBefore;
    FetchPkg::PcPath expPc;
    name = "sequentialFetch";
    errorsBefore = errorCount;
    @(negedge clk);
    checkPc(name, FetchPkg::RESET_PC, icReadAddr);
    checkEmpty(name);
    waitForGroup(name, FetchPkg::RESET_PC, 4);
    expPc = FetchPkg::RESET_PC;
    for (int n = 0; n < 4; n++) begin
        if (n > 0) begin
            @(negedge clk);
        end
        checkGroup(name, expPc);
        checkPc(name, groupAfter(expPc), icReadAddr);
        expPc = groupAfter(expPc);
    end
    reportTest(name, errorsBefore);
endtask

task automatic lineBoundary();
    string name;
    int errorsBefore;
    FetchPkg::PcPath intPc;
    FetchPkg::PcPath lineNext;
    name = "lineBoundary";
    errorsBefore = errorCount;
    intPc = randomLinePc(32'h0010_0000) | 32'h8;
    lineNext = intPc - (intPc % FetchPkg::LINE_BYTES) + FetchPkg::PcPath'(FetchPkg::LINE_BYTES);
    @(posedge clk);
    interruptWe <= 1'b1;
    interruptPc <= intPc;
    @(posedge clk);
    interruptWe <= 1'b0;
    // Group formed in the interrupt cycle
    @(negedge clk);
    checkEmpty(name);
    @(negedge clk);
    checkGroup(name, intPc);
    checkPc(name, lineNext, icReadAddr);
    @(negedge clk);
    checkGroup(name, lineNext);
    reportTest(name, errorsBefore);
endtask

task automatic predictedBranch();
    string name;
    int errorsBefore;
    FetchPkg::PcPath base;
    FetchPkg::PcPath target;
    name = "predictedBranch";
    errorsBefore = errorCount;
    base = randomLinePc(32'h0020_0000);
    target = randomLinePc(32'h0030_0000);
    // Two taken updates take the counter from weakly not-taken to strongly taken
    @(posedge clk);
    updateWe <= 1'b1;
    updatePc <= base + 32'h4;
    updateTarget <= target;
    updateTaken <= 1'b1;
    updateHistory <= '0;
    @(posedge clk);
    @(posedge clk);
    updateWe <= 1'b0;
    decodeRecover <= 1'b1;
    decodeRecoverPc <= base;
    decodeHistory <= '0;
    @(posedge clk);
    decodeRecover <= 1'b0;
    @(negedge clk);
    checkGroup(name, base);
    checkTaken(name, 1);
    checkPc(name, target, icReadAddr);
    @(negedge clk);
    checkGroup(name, target);
    checkTaken(name, -1);
    reportTest(name, errorsBefore);
endtask

task automatic recoveryPriority();
    string name;
    int errorsBefore;
    FetchPkg::PcPath cPc;
    FetchPkg::PcPath dPc;
    name = "recoveryPriority";
    errorsBefore = errorCount;
    cPc = randomLinePc(32'h0040_0000);
    dPc = randomLinePc(32'h0050_0000);
    @(posedge clk);
    commitRecover <= 1'b1;
    commitPc <= cPc;
    commitHistory <= '0;
    decodeRecover <= 1'b1;
    decodeRecoverPc <= dPc;
    decodeHistory <= '0;
    @(negedge clk);
    checkPc(name, cPc, icReadAddr);
    @(posedge clk);
    commitRecover <= 1'b0;
    @(negedge clk);
    checkGroup(name, cPc);
    checkPc(name, dPc, icReadAddr);
    @(posedge clk);
    decodeRecover <= 1'b0;
    @(negedge clk);
    checkGroup(name, dPc);
    reportTest(name, errorsBefore);
endtask

task automatic stallHold();
    string name;
    int errorsBefore;
    FetchPkg::PcPath stallPc;
    name = "stallHold";
    errorsBefore = errorCount;
    stallPc = randomLinePc(32'h0060_0000);
    @(posedge clk);
    decodeRecover <= 1'b1;
    decodeRecoverPc <= stallPc;
    @(posedge clk);
    decodeRecover <= 1'b0;
    stall <= 1'b1;
    // The group at stallPc stays in the fetch stage, nothing is trained there
    repeat (4) begin
        @(negedge clk);
        checkGroup(name, stallPc);
        checkTaken(name, -1);
        checkPc(name, stallPc, icReadAddr);
    end
    @(posedge clk);
    stall <= 1'b0;
    // Register still holds in the release cycle while the address moves on
    @(negedge clk);
    checkGroup(name, stallPc);
    checkPc(name, groupAfter(stallPc), icReadAddr);
    @(negedge clk);
    checkGroup(name, groupAfter(stallPc));
    reportTest(name, errorsBefore);
endtask

task automatic clearGroup();
    string name;
    int errorsBefore;
    FetchPkg::PcPath clearedPc;
    name = "clearGroup";
    errorsBefore = errorCount;
    clearedPc = randomLinePc(32'h0070_0000);
    @(posedge clk);
    decodeRecover <= 1'b1;
    decodeRecoverPc <= clearedPc;
    clear <= 1'b1;
    @(posedge clk);
    decodeRecover <= 1'b0;
    clear <= 1'b0;
    @(negedge clk);
    checkEmpty(name);
    checkPc(name, clearedPc, fetchPc[0]);
    waitForGroup(name, groupAfter(clearedPc), 4);
    checkGroup(name, groupAfter(clearedPc));
    reportTest(name, errorsBefore);
endtask

//--- test/FetchFrontEndTb.sv
/*
 * Testbench for the fetch front end: clock, reset, DUT instance,
 * directed test sequence and the closing summary
 */
`timescale 1ns/1ps

module FetchFrontEndTb;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    logic interruptWe;
    FetchPkg::PcPath interruptPc;
    logic commitRecover;
    FetchPkg::PcPath commitPc;
    FetchPkg::HistoryPath commitHistory;
    logic decodeRecover;
    FetchPkg::PcPath decodeRecoverPc;
    FetchPkg::HistoryPath decodeHistory;
    logic updateWe;
    FetchPkg::PcPath updatePc;
    FetchPkg::PcPath updateTarget;
    logic updateTaken;
    FetchPkg::HistoryPath updateHistory;

    FetchPkg::PcPath icReadAddr;
    logic [FetchPkg::FETCH_WIDTH-1:0] fetchValid;
    FetchPkg::PcPath fetchPc [FetchPkg::FETCH_WIDTH];
    logic [FetchPkg::FETCH_WIDTH-1:0] fetchPredTaken;

    int errorCount;
    int testCount;
    int failedTests;

    FetchFrontEnd FetchFrontEnd_inst (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .clear           (clear),
        .interruptWe     (interruptWe),
        .interruptPc     (interruptPc),
        .commitRecover   (commitRecover),
        .commitPc        (commitPc),
        .commitHistory   (commitHistory),
        .decodeRecover   (decodeRecover),
        .decodeRecoverPc (decodeRecoverPc),
        .decodeHistory   (decodeHistory),
        .updateWe        (updateWe),
        .updatePc        (updatePc),
        .updateTarget    (updateTarget),
        .updateTaken     (updateTaken),
        .updateHistory   (updateHistory),
        .icReadAddr      (icReadAddr),
        .fetchValid      (fetchValid),
        .fetchPc         (fetchPc),
        .fetchPredTaken  (fetchPredTaken)
    );

    `include "FetchTbTasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        // Idle inputs with reset held
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        interruptWe = 1'b0;
        interruptPc = '0;
        commitRecover = 1'b0;
        commitPc = '0;
        commitHistory = '0;
        decodeRecover = 1'b0;
        decodeRecoverPc = '0;
        decodeHistory = '0;
        updateWe = 1'b0;
        updatePc = '0;
        updateTarget = '0;
        updateTaken = 1'b0;
        updateHistory = '0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        void'($urandom(18));

        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        sequentialFetch();
        lineBoundary();
        predictedBranch();
        recoveryPriority();
        stallHold();
        clearGroup();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src/FetchFrontEnd.sv
/*
 * Top level of the instruction-fetch front end: next-PC stage,
 * branch predictor and fetch stage, with plain ports
 */
`timescale 1ns/1ps

module FetchFrontEnd (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  logic                 clear,
    input  logic                 interruptWe,
    input  FetchPkg::PcPath      interruptPc,
    input  logic                 commitRecover,
    input  FetchPkg::PcPath      commitPc,
    input  FetchPkg::HistoryPath commitHistory,
    input  logic                 decodeRecover,
    input  FetchPkg::PcPath      decodeRecoverPc,
    input  FetchPkg::HistoryPath decodeHistory,
    input  logic                 updateWe,
    input  FetchPkg::PcPath      updatePc,
    input  FetchPkg::PcPath      updateTarget,
    input  logic                 updateTaken,
    input  FetchPkg::HistoryPath updateHistory,
    output FetchPkg::PcPath      icReadAddr,
    output logic [FetchPkg::FETCH_WIDTH-1:0] fetchValid,
    output FetchPkg::PcPath      fetchPc [FetchPkg::FETCH_WIDTH],
    output logic [FetchPkg::FETCH_WIDTH-1:0] fetchPredTaken
);

    FetchStageIF fetchIf ();
    RecoveryIF recoveryIf ();

    FetchPkg::PcPath predNextPc;
    FetchPkg::FetchGroup nextGroup;
    logic groupAdvance;

    assign recoveryIf.commitRecover = commitRecover;
    assign recoveryIf.commitPc = commitPc;
    assign recoveryIf.commitHistory = commitHistory;
    assign recoveryIf.decodeRecover = decodeRecover;
    assign recoveryIf.decodeRecoverPc = decodeRecoverPc;
    assign recoveryIf.decodeHistory = decodeHistory;

    NextPcStage nextPcStage (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .clear        (clear),
        .interruptWe  (interruptWe),
        .interruptPc  (interruptPc),
        .fetch        (fetchIf.NextPcStage),
        .recovery     (recoveryIf.NextPcStage),
        .predNextPc   (predNextPc),
        .nextGroup    (nextGroup),
        .groupAdvance (groupAdvance),
        .icReadAddr   (icReadAddr)
    );

    BranchPredictor branchPredictor (
        .clk           (clk),
        .rstN          (rstN),
        .predNextPc    (predNextPc),
        .groupAdvance  (groupAdvance),
        .updateWe      (updateWe),
        .updatePc      (updatePc),
        .updateTarget  (updateTarget),
        .updateTaken   (updateTaken),
        .updateHistory (updateHistory),
        .fetch         (fetchIf.Predictor),
        .recovery      (recoveryIf.Predictor)
    );

    FetchStage fetchStage (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .nextGroup (nextGroup),
        .fetch     (fetchIf.Fetch)
    );

    assign fetchValid = fetchIf.groupValid;
    assign fetchPc = fetchIf.groupPc;
    // Predictions only for slots that hold an instruction
    assign fetchPredTaken = fetchIf.predTaken & fetchIf.groupValid;

endmodule

//--- src/FetchStage.sv
/*
 * Fetch-stage register for one fetch group, held on stall
 */
`timescale 1ns/1ps

module FetchStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  FetchPkg::FetchGroup nextGroup,
    FetchStageIF.Fetch          fetch
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetch.groupValid <= '0;
        end else if (!stall) begin
            for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
                fetch.groupValid[i] <= nextGroup[i].valid;
            end
        end
    end

    // Slot 0 PC also feeds the I-cache address while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
                fetch.groupPc[i] <= nextGroup[i].pc;
            end
        end
    end

    // Line stop and clear only ever drop the tail of a group
    validSlotsContiguous: assert property (
        @(posedge clk) disable iff (!rstN)
        (fetch.groupValid & (fetch.groupValid + 1'b1)) == '0
    ) else $error("Valid slot follows an invalid slot");

endmodule

//--- src/BranchPredictor.sv
/*
 * Branch predictor: direct-mapped BTB, gshare counter table and
 * global history with recovery, registered lookup per fetch slot
 */
`timescale 1ns/1ps

module BranchPredictor (
    input  logic                 clk,
    input  logic                 rstN,
    input  FetchPkg::PcPath      predNextPc,
    input  logic                 groupAdvance,
    input  logic                 updateWe,
    input  FetchPkg::PcPath      updatePc,
    input  FetchPkg::PcPath      updateTarget,
    input  logic                 updateTaken,
    input  FetchPkg::HistoryPath updateHistory,
    FetchStageIF.Predictor       fetch,
    RecoveryIF.Predictor         recovery
);

    logic btbValid [FetchPkg::BTB_ENTRIES];
    FetchPkg::BtbTag btbTag [FetchPkg::BTB_ENTRIES];
    FetchPkg::PcPath btbTargetMem [FetchPkg::BTB_ENTRIES];
    FetchPkg::PhtCounter pht [FetchPkg::PHT_ENTRIES];

    FetchPkg::HistoryPath history;
    FetchPkg::HistoryPath nextHistory;
    logic anyTaken;

    FetchPkg::PcPath slotPc [FetchPkg::FETCH_WIDTH];
    logic [FetchPkg::FETCH_WIDTH-1:0] lookupHit;
    logic [FetchPkg::FETCH_WIDTH-1:0] lookupTaken;
    FetchPkg::PcPath lookupTarget [FetchPkg::FETCH_WIDTH];

    FetchPkg::BtbIndex updBtbIndex;
    FetchPkg::PhtIndex updPhtIndex;
    FetchPkg::PhtCounter curCounter;
    FetchPkg::PhtCounter newCounter;

    function automatic FetchPkg::BtbIndex btbIndexOf(FetchPkg::PcPath pc);
        return pc[FetchPkg::INSN_OFFSET_BIT +: FetchPkg::BTB_INDEX_WIDTH];
    endfunction

    function automatic FetchPkg::BtbTag btbTagOf(FetchPkg::PcPath pc);
        return pc[FetchPkg::PC_WIDTH-1 -: FetchPkg::BTB_TAG_WIDTH];
    endfunction

    function automatic FetchPkg::PhtIndex phtIndexOf(FetchPkg::PcPath pc,
                                                     FetchPkg::HistoryPath hist);
        return pc[FetchPkg::INSN_OFFSET_BIT +: FetchPkg::PHT_INDEX_WIDTH] ^ hist;
    endfunction

    // Recovery restores the history, otherwise shift on each consumed group
    always_comb begin
        anyTaken = |(fetch.groupValid & fetch.predTaken);
        if (recovery.commitRecover) begin
            nextHistory = recovery.commitHistory;
        end else if (recovery.decodeRecover) begin
            nextHistory = recovery.decodeHistory;
        end else if (groupAdvance) begin
            nextHistory = {history[FetchPkg::HISTORY_WIDTH-2:0], anyTaken};
        end else begin
            nextHistory = history;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            history <= '0;
        end else begin
            history <= nextHistory;
        end
    end

    // Lookup uses the history the looked-up group will see
    always_comb begin
        for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
            slotPc[i] = predNextPc + FetchPkg::PcPath'(i * FetchPkg::INSN_BYTES);
            lookupHit[i] = btbValid[btbIndexOf(slotPc[i])]
                           && (btbTag[btbIndexOf(slotPc[i])] == btbTagOf(slotPc[i]));
            lookupTaken[i] = lookupHit[i] && pht[phtIndexOf(slotPc[i], nextHistory)][1];
            lookupTarget[i] = btbTargetMem[btbIndexOf(slotPc[i])];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetch.btbHit <= '0;
            fetch.predTaken <= '0;
        end else begin
            fetch.btbHit <= lookupHit;
            fetch.predTaken <= lookupTaken;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
            fetch.btbTarget[i] <= lookupTarget[i];
        end
    end

    // Training moves a saturating two-bit counter
    always_comb begin
        updBtbIndex = btbIndexOf(updatePc);
        updPhtIndex = phtIndexOf(updatePc, updateHistory);
        curCounter = pht[updPhtIndex];
        newCounter = curCounter;
        if (updateTaken && curCounter != 2'b11) begin
            newCounter = curCounter + 2'b01;
        end else if (!updateTaken && curCounter != 2'b00) begin
            newCounter = curCounter - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < FetchPkg::BTB_ENTRIES; i++) begin
                btbValid[i] <= 1'b0;
            end
        end else if (updateWe) begin
            btbValid[updBtbIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updateWe) begin
            btbTag[updBtbIndex] <= btbTagOf(updatePc);
            btbTargetMem[updBtbIndex] <= updateTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < FetchPkg::PHT_ENTRIES; i++) begin
                pht[i] <= FetchPkg::PHT_WEAK_NOT_TAKEN;
            end
        end else if (updateWe) begin
            pht[updPhtIndex] <= newCounter;
        end
    end

    // Also needs a known predNextPc from the next-PC stage
    predTakenKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        !$isunknown(fetch.predTaken)
    ) else $error("Unknown value on predTaken");

endmodule

//--- src/NextPcStage.sv
/*
 * Next-PC stage: PC register, redirect priority, fetch-group
 * formation with the cache-line stop, and the I-cache read address
 */
`timescale 1ns/1ps

module NextPcStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  logic                clear,
    input  logic                interruptWe,
    input  FetchPkg::PcPath     interruptPc,
    FetchStageIF.NextPcStage    fetch,
    RecoveryIF.NextPcStage      recovery,
    output FetchPkg::PcPath     predNextPc,
    output FetchPkg::FetchGroup nextGroup,
    output logic                groupAdvance,
    output FetchPkg::PcPath     icReadAddr
);

    FetchPkg::PcPath pc;
    FetchPkg::PcPath pcIn;
    FetchPkg::PcPath predTarget;
    logic regStall;
    logic beginStall;
    logic predFound;
    logic usePred;
    logic writeFromOuter;
    logic pcWe;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regStall <= 1'b0;
        end else begin
            regStall <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= FetchPkg::RESET_PC;
        end else if (pcWe) begin
            pc <= pcIn;
        end
    end

    // Lowest valid slot predicted taken while no stall holds the group
    always_comb begin
        predFound = 1'b0;
        predTarget = pc;
        for (int i = FetchPkg::FETCH_WIDTH - 1; i >= 0; i--) begin
            if (!regStall && fetch.groupValid[i] && fetch.btbHit[i] && fetch.predTaken[i]) begin
                predFound = 1'b1;
                predTarget = fetch.btbTarget[i];
            end
        end
    end

    // Commit beats decode, decode beats the prediction
    always_comb begin
        usePred = 1'b0;
        if (recovery.commitRecover) begin
            predNextPc = recovery.commitPc;
        end else if (recovery.decodeRecover) begin
            predNextPc = recovery.decodeRecoverPc;
        end else if (predFound) begin
            predNextPc = predTarget;
            usePred = 1'b1;
        end else begin
            predNextPc = pc;
        end
    end

    always_comb begin
        beginStall = !regStall && stall;
        writeFromOuter = recovery.commitRecover || recovery.decodeRecover
                         || interruptWe || usePred;
        pcWe = writeFromOuter || !stall || beginStall;
        groupAdvance = !regStall && !stall;
    end

    // Group slots and the PC that follows them
    always_comb begin
        for (int i = 0; i < FetchPkg::FETCH_WIDTH; i++) begin
            nextGroup[i].pc = predNextPc + FetchPkg::PcPath'(i * FetchPkg::INSN_BYTES);
            nextGroup[i].valid = !(interruptWe || clear
                                   || FetchPkg::stepsOverLine(predNextPc, nextGroup[i].pc));
        end

        if (interruptWe) begin
            pcIn = interruptPc;
        end else if (stall) begin
            // The group at predNextPc is not taken by the fetch stage yet
            pcIn = predNextPc;
        end else begin
            pcIn = predNextPc
                   + FetchPkg::PcPath'(FetchPkg::FETCH_WIDTH * FetchPkg::INSN_BYTES);
            // Stop at the first slot in the next line
            for (int i = FetchPkg::FETCH_WIDTH - 1; i >= 1; i--) begin
                if (FetchPkg::stepsOverLine(predNextPc, nextGroup[i].pc)) begin
                    pcIn = nextGroup[i].pc;
                end
            end
        end
    end

    // Keep reading the held line while stalled
    always_comb begin
        if (fetch.groupValid[0] && stall) begin
            icReadAddr = fetch.groupPc[0];
        end else begin
            icReadAddr = predNextPc;
        end
    end

    // The group fetched after a commit recovery starts at commitPc and not at a target
    commitOverridesPrediction: assert property (
        @(posedge clk) disable iff (!rstN)
        (recovery.commitRecover && !stall) |=> (fetch.groupPc[0] == $past(recovery.commitPc))
    ) else $error("Fetch group after commit recovery does not start at commitPc");

    // An interrupt cycle leaves an empty group behind it
    interruptEmptiesGroup: assert property (
        @(posedge clk) disable iff (!rstN)
        (interruptWe && !stall) |=> (fetch.groupValid == '0)
    ) else $error("Group after an interrupt write holds valid slots");

endmodule

//--- src/RecoveryIF.sv
/*
 * Redirect requests from commit and decode, with the PC to
 * restart from and the global history to restore
 */
`timescale 1ns/1ps

interface RecoveryIF;

    logic commitRecover;
    FetchPkg::PcPath commitPc;
    FetchPkg::HistoryPath commitHistory;

    logic decodeRecover;
    FetchPkg::PcPath decodeRecoverPc;
    FetchPkg::HistoryPath decodeHistory;

    modport Source (
        output commitRecover, commitPc, commitHistory,
        output decodeRecover, decodeRecoverPc, decodeHistory
    );

    modport NextPcStage (input commitRecover, commitPc, decodeRecover, decodeRecoverPc);

    modport Predictor (input commitRecover, commitHistory, decodeRecover, decodeHistory);

endinterface

//--- src/FetchStageIF.sv
/*
 * Fetch-stage contents and the registered branch predictions
 * for the same group, read back by the next-PC stage
 */
`timescale 1ns/1ps

interface FetchStageIF;

    // Driven by the fetch stage register
    logic [FetchPkg::FETCH_WIDTH-1:0] groupValid;
    FetchPkg::PcPath groupPc [FetchPkg::FETCH_WIDTH];

    // Driven by the branch predictor, aligned with the group above
    logic [FetchPkg::FETCH_WIDTH-1:0] btbHit;
    logic [FetchPkg::FETCH_WIDTH-1:0] predTaken;
    FetchPkg::PcPath btbTarget [FetchPkg::FETCH_WIDTH];

    modport NextPcStage (
        input groupValid, groupPc, btbHit, predTaken, btbTarget
    );

    modport Fetch (
        output groupValid, groupPc
    );

    modport Predictor (
        input groupValid,
        output btbHit, predTaken, btbTarget
    );

endinterface

//--- src/FetchPkg.sv
/*
 * Shared definitions of the fetch front end: PC and history widths,
 * reset PC, cache-line and predictor geometry, the fetch-slot types
 * and the cache-line boundary check
 */
package FetchPkg;

    localparam int PC_WIDTH = 32;
    typedef logic [PC_WIDTH-1:0] PcPath;

    // Fetch group and cache-line geometry
    localparam int FETCH_WIDTH = 4;
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET_BIT = $clog2(INSN_BYTES);
    localparam int LINE_BYTES = 16;
    localparam int LINE_BIT = $clog2(LINE_BYTES);

    localparam PcPath RESET_PC = 32'h0000_1000;

    localparam int HISTORY_WIDTH = 6;
    typedef logic [HISTORY_WIDTH-1:0] HistoryPath;

    // Direct-mapped BTB, indexed by PC bits 5..2
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_WIDTH = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - INSN_OFFSET_BIT;
    typedef logic [BTB_INDEX_WIDTH-1:0] BtbIndex;
    typedef logic [BTB_TAG_WIDTH-1:0] BtbTag;

    // Gshare counter table, PC bits 7..2 xor the global history
    localparam int PHT_ENTRIES = 64;
    localparam int PHT_INDEX_WIDTH = $clog2(PHT_ENTRIES);
    typedef logic [PHT_INDEX_WIDTH-1:0] PhtIndex;
    typedef logic [1:0] PhtCounter;
    localparam PhtCounter PHT_WEAK_NOT_TAKEN = 2'b01;

    // One instruction slot of a fetch group
    typedef struct packed {
        logic valid;
        PcPath pc;
    } FetchSlot;

    typedef FetchSlot FetchGroup [FETCH_WIDTH];

    // True when the two PCs lie in different cache lines
    function automatic logic stepsOverLine(PcPath pc1, PcPath pc2);
        return pc1[LINE_BIT] != pc2[LINE_BIT];
    endfunction

endpackage
